// File: common/mem_port_if.sv
`default_nettype none
`include "rv_settings.svh"

// data memory port, single cycle, no handshake
interface mem_port_if;
  logic [`XLEN-1:0] addr;  // byte address, word aligned
  logic [`XLEN-1:0] wdata;
  logic [`XLEN-1:0] rdata; // zero unless read
  logic             read;
  logic             write; // lands at the rising edge

  modport pipeline (output addr, wdata, read, write, input rdata);
  modport memory   (input addr, wdata, read, write, output rdata);
endinterface

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011, // add sub and or slt
    op_imm    = 7'b0010011, // addi
    op_load   = 7'b0000011, // lw
    op_store  = 7'b0100011, // sw
    op_branch = 7'b1100011, // beq bne
    op_jal    = 7'b1101111,
    op_system = 7'b1110011  // ecall
  } opcode_e;

  // alu operation, picked in ex from opcode and funct bits
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

  // where an ex operand comes from
  typedef enum logic [1:0] {
    fwd_none   = 2'd0, // value read in id
    fwd_ex_mem = 2'd1, // result one stage ahead
    fwd_mem_wb = 2'd2  // writeback value
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define XLEN 32

// instruction rom depth in words
`define IMEM_WORDS 256

// data ram depth in words
`define DMEM_WORDS 64

// register index width
`define REG_ADDR_W 5

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// File: cpu_core/alu_unit.sv
`default_nettype none
`include "rv_settings.svh"

module alu_unit import rv_pkg::*; (
  input  wire opcode_e     opcode,
  input  wire  [2:0]       funct3,
  input  wire              funct7_bit, // inst[30], sub vs add
  input  wire  [`XLEN-1:0] in_a,
  input  wire  [`XLEN-1:0] in_b,
  output logic [`XLEN-1:0] result,
  output logic             take_branch
);

  alu_op_e op;

  // alu control, everything but r-type and branches adds
  always_comb begin
    op = alu_add; // addi, lw, sw address
    if (opcode == op_branch) begin
      op = alu_sub; // compare by difference
    end else if (opcode == op_reg) begin
      case (funct3)
        3'b000:  op = funct7_bit ? alu_sub : alu_add;
        3'b010:  op = alu_slt;
        3'b110:  op = alu_or;
        3'b111:  op = alu_and;
        default: op = alu_add;
      endcase
    end
  end

  always_comb begin
    case (op)
      alu_sub: result = in_a - in_b;
      alu_and: result = in_a & in_b;
      alu_or:  result = in_a | in_b;
      alu_slt: result = {{(`XLEN-1){1'b0}}, $signed(in_a) < $signed(in_b)};
      default: result = in_a + in_b;
    endcase
  end

  // beq on funct3 000, bne on 001
  assign take_branch = (opcode == op_branch) && ((result == '0) ^ funct3[0]);

endmodule

`default_nettype wire

// File: cpu_core/cpu_top.sv
`default_nettype none
`include "rv_settings.svh"

module cpu_top (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    load_en,   // program load, during reset only
  input  wire  [`XLEN-1:0]       load_addr,
  input  wire  [`XLEN-1:0]       load_data,
  output logic                   is_halted,
  output logic                   wb_valid,  // writeback trace
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0]       pc, inst;
  logic [`REG_ADDR_W-1:0] rs1_idx, rs2_idx, rf_rd;
  logic [`XLEN-1:0]       rs1_data, rs2_data, rf_wdata;
  logic                   rf_we;

  mem_port_if dmem_bus ();

  rv_pipeline u_pipeline (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rf_we     (rf_we),
    .rf_rd     (rf_rd),
    .rf_wdata  (rf_wdata),
    .dmem      (dmem_bus.pipeline),
    .is_halted (is_halted),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  inst_memory u_imem (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .addr      (pc),
    .inst      (inst)
  );

  data_memory u_dmem (
    .clk   (clk),
    .reset (reset),
    .mem   (dmem_bus.memory)
  );

  register_file u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .we       (rf_we),
    .rd       (rf_rd),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

`default_nettype wire

// File: cpu_core/decode_unit.sv
`default_nettype none
`include "rv_settings.svh"

module decode_unit import rv_pkg::*; (
  input  wire  [`XLEN-1:0] inst,
  output opcode_e          opcode,
  output logic             reg_write,
  output logic             mem_read,
  output logic             mem_write,
  output logic             alu_src,   // operand b from imm
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_ecall,
  output logic [`XLEN-1:0] imm
);

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);

  // sign extended immediates, b and j keep bit 0 at zero
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_src   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_ecall  = 1'b0;
    imm       = '0;
    case (opcode)
      op_reg: reg_write = 1'b1;
      op_imm: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        imm       = imm_i;
      end
      op_load: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        alu_src   = 1'b1; // rs1 + offset
        imm       = imm_i;
      end
      op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        imm       = imm_s;
      end
      op_branch: begin
        is_branch = 1'b1; // alu compares rs1 and rs2
        imm       = imm_b;
      end
      op_jal: begin
        reg_write = 1'b1; // link pc+4
        is_jal    = 1'b1;
        imm       = imm_j;
      end
      op_system: is_ecall = (inst[31:7] == '0); // ecall only, no csr
      default: ; // unknown, leaves a bubble
    endcase
  end

endmodule

`default_nettype wire

// File: cpu_core/hazard_unit.sv
`default_nettype none
`include "rv_settings.svh"

module hazard_unit import rv_pkg::*; (
  input  wire [`REG_ADDR_W-1:0] id_rs1,
  input  wire [`REG_ADDR_W-1:0] id_rs2,
  input  wire [`REG_ADDR_W-1:0] ex_rs1,
  input  wire [`REG_ADDR_W-1:0] ex_rs2,
  input  wire [`REG_ADDR_W-1:0] ex_rd,
  input  wire [`REG_ADDR_W-1:0] mem_rd,
  input  wire [`REG_ADDR_W-1:0] wb_rd,
  input  wire                   ex_mem_read,   // lw in ex
  input  wire                   mem_reg_write,
  input  wire                   wb_reg_write,
  output logic                  stall,
  output fwd_sel_e              fwd_a,
  output fwd_sel_e              fwd_b
);

  // youngest producer wins and x0 is never forwarded
  function automatic fwd_sel_e pick(input logic [`REG_ADDR_W-1:0] src);
    if (src == '0) return fwd_none;
    if (mem_reg_write && mem_rd == src) return fwd_ex_mem;
    if (wb_reg_write && wb_rd == src) return fwd_mem_wb;
    return fwd_none;
  endfunction

  always_comb begin
    // lw data exists only after mem, so the consumer waits one cycle
    stall = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
    fwd_a = pick(ex_rs1);
    fwd_b = pick(ex_rs2);
  end

  // producers in mem and wb never target x0
  always_comb begin
    a_no_x0_producer: assert final (!(mem_reg_write === 1'b1 && mem_rd == '0) &&
                                    !(wb_reg_write === 1'b1 && wb_rd == '0));
  end

endmodule

`default_nettype wire

// File: cpu_core/rv_pipeline.sv
`default_nettype none
`include "rv_settings.svh"

module rv_pipeline import rv_pkg::*; (
  input  wire                    clk,
  input  wire                    reset,
  output logic [`XLEN-1:0]       pc,
  input  wire  [`XLEN-1:0]       inst,
  output logic [`REG_ADDR_W-1:0] rs1_idx,
  output logic [`REG_ADDR_W-1:0] rs2_idx,
  input  wire  [`XLEN-1:0]       rs1_data,
  input  wire  [`XLEN-1:0]       rs2_data,
  output logic                   rf_we,
  output logic [`REG_ADDR_W-1:0] rf_rd,
  output logic [`XLEN-1:0]       rf_wdata,
  mem_port_if.pipeline           dmem,
  output logic                   is_halted,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  // if/id
  logic [`XLEN-1:0] fd_pc;
  logic [`XLEN-1:0] fd_inst;
  // id decode
  opcode_e                id_opcode;
  logic                   id_reg_write, id_mem_read, id_mem_write, id_alu_src;
  logic                   id_is_branch, id_is_jal, id_is_ecall;
  logic [`XLEN-1:0]       id_imm;
  logic [`REG_ADDR_W-1:0] id_rd;
  // id/ex
  opcode_e                de_opcode;
  logic                   de_reg_write, de_mem_read, de_mem_write, de_alu_src;
  logic                   de_is_branch, de_is_jal, de_is_ecall;
  logic [`XLEN-1:0]       de_pc, de_imm, de_rs1_data, de_rs2_data;
  logic [`REG_ADDR_W-1:0] de_rs1, de_rs2, de_rd;
  logic [2:0]             de_funct3;
  logic                   de_funct7;
  // ex
  fwd_sel_e         fwd_a, fwd_b;
  logic             stall, flush, take_branch, ex_halt;
  logic [`XLEN-1:0] ex_a, ex_b_reg, ex_alu_b, alu_result, ex_result, ex_target;
  // ex/mem
  logic                   em_reg_write, em_mem_read, em_mem_write;
  logic                   em_halt; // sticky once the halting ecall passes ex
  logic [`XLEN-1:0]       em_result, em_store_data;
  logic [`REG_ADDR_W-1:0] em_rd;
  // mem/wb
  logic                   mw_reg_write, mw_halt;
  logic [`REG_ADDR_W-1:0] mw_rd;
  logic [`XLEN-1:0]       mw_data;

  // ex operand from id read or a younger result
  function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [`XLEN-1:0] rf_val);
    case (sel)
      fwd_ex_mem: return em_result;
      fwd_mem_wb: return mw_data;
      default:    return rf_val;
    endcase
  endfunction

  // halt freezes the pc and a redirect beats the load-use hold
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!em_halt) begin
      if (flush) pc <= ex_target;
      else if (!stall) pc <= pc + 'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      fd_inst <= `NOP_INST; // squash the wrong-path fetch
    end else if (!stall) begin
      fd_inst <= inst;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) fd_pc <= pc;
  end

  decode_unit u_decode (
    .inst      (fd_inst),
    .opcode    (id_opcode),
    .reg_write (id_reg_write),
    .mem_read  (id_mem_read),
    .mem_write (id_mem_write),
    .alu_src   (id_alu_src),
    .is_branch (id_is_branch),
    .is_jal    (id_is_jal),
    .is_ecall  (id_is_ecall),
    .imm       (id_imm)
  );

  assign id_rd   = fd_inst[11:7];
  assign rs1_idx = id_is_ecall ? `REG_ADDR_W'd17 : fd_inst[19:15]; // ecall looks at a7
  assign rs2_idx = fd_inst[24:20];

  // id/ex control clears to a bubble on stall or flush
  always_ff @(posedge clk) begin
    if (reset || stall || flush) begin
      de_opcode    <= op_imm;
      de_reg_write <= 1'b0;
      de_mem_read  <= 1'b0;
      de_mem_write <= 1'b0;
      de_alu_src   <= 1'b0;
      de_is_branch <= 1'b0;
      de_is_jal    <= 1'b0;
      de_is_ecall  <= 1'b0;
    end else begin
      de_opcode    <= id_opcode;
      de_reg_write <= id_reg_write && id_rd != '0; // x0 targets never retire
      de_mem_read  <= id_mem_read;
      de_mem_write <= id_mem_write;
      de_alu_src   <= id_alu_src;
      de_is_branch <= id_is_branch;
      de_is_jal    <= id_is_jal;
      de_is_ecall  <= id_is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    de_pc       <= fd_pc;
    de_imm      <= id_imm;
    de_rs1_data <= rs1_data;
    de_rs2_data <= rs2_data;
    de_rs1      <= rs1_idx;
    de_rs2      <= rs2_idx;
    de_rd       <= id_rd;
    de_funct3   <= fd_inst[14:12];
    de_funct7   <= fd_inst[30];
  end

  hazard_unit u_hazard (
    .id_rs1        (rs1_idx),
    .id_rs2        (rs2_idx),
    .ex_rs1        (de_rs1),
    .ex_rs2        (de_rs2),
    .ex_rd         (de_rd),
    .mem_rd        (em_rd),
    .wb_rd         (mw_rd),
    .ex_mem_read   (de_mem_read),
    .mem_reg_write (em_reg_write),
    .wb_reg_write  (mw_reg_write),
    .stall         (stall),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  always_comb begin
    ex_a     = fwd_mux(fwd_a, de_rs1_data);
    ex_b_reg = fwd_mux(fwd_b, de_rs2_data); // also the sw data
    ex_alu_b = de_alu_src ? de_imm : ex_b_reg;
  end

  alu_unit u_alu (
    .opcode      (de_opcode),
    .funct3      (de_funct3),
    .funct7_bit  (de_funct7),
    .in_a        (ex_a),
    .in_b        (ex_alu_b),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  assign ex_target = de_pc + de_imm;                          // branch and jal target
  assign ex_result = de_is_jal ? de_pc + 'd4 : alu_result;    // link rides the result
  assign flush     = ((de_is_branch && take_branch) || de_is_jal) && !em_halt;
  assign ex_halt   = de_is_ecall && ex_a == `XLEN'd10;        // x17 holds 10

  // nothing younger than the halting ecall leaves ex
  always_ff @(posedge clk) begin
    if (reset) begin
      em_reg_write <= 1'b0;
      em_mem_read  <= 1'b0;
      em_mem_write <= 1'b0;
      em_halt      <= 1'b0;
    end else begin
      em_reg_write <= de_reg_write && !em_halt;
      em_mem_read  <= de_mem_read && !em_halt;
      em_mem_write <= de_mem_write && !em_halt;
      em_halt      <= em_halt || ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    em_result     <= ex_result;
    em_store_data <= ex_b_reg;
    em_rd         <= de_rd;
  end

  assign dmem.addr  = em_result;
  assign dmem.wdata = em_store_data;
  assign dmem.read  = em_mem_read;
  assign dmem.write = em_mem_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      mw_reg_write <= 1'b0;
      mw_halt      <= 1'b0;
    end else begin
      mw_reg_write <= em_reg_write;
      mw_halt      <= em_halt; // high from the ecall's wb cycle on
    end
  end

  always_ff @(posedge clk) begin
    mw_rd   <= em_rd;
    mw_data <= em_mem_read ? dmem.rdata : em_result; // lw data or alu/link
  end

  assign rf_we     = mw_reg_write;
  assign rf_rd     = mw_rd;
  assign rf_wdata  = mw_data;
  assign wb_valid  = mw_reg_write; // one pulse per retired write
  assign wb_rd     = mw_rd;
  assign wb_data   = mw_data;
  assign is_halted = mw_halt;

  // once halted the core stays halted and retires nothing
  a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted && !wb_valid);

  // a load and a taken jump never sit in ex together
  a_no_stall_with_flush: assert property (@(posedge clk) disable iff (reset)
    !(stall && flush));

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/rv_pkg.sv
common/mem_port_if.sv
src/register_file.sv
src/inst_memory.sv
src/data_memory.sv
cpu_core/decode_unit.sv
cpu_core/alu_unit.sv
cpu_core/hazard_unit.sv
cpu_core/rv_pipeline.sv
cpu_core/cpu_top.sv
verification/tb_clock_gen.sv
verification/cpu_tb.sv

// File: src/data_memory.sv
`default_nettype none
`include "rv_settings.svh"

module data_memory (
  input wire         clk,
  input wire         reset,
  mem_port_if.memory mem
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0] ram [`DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = mem.addr[IDX_W+1:2]; // word index, upper bits ignored

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `DMEM_WORDS; i++) ram[i] <= '0;
    end else if (mem.write) begin
      ram[idx] <= mem.wdata;
    end
  end

  assign mem.rdata = mem.read ? ram[idx] : '0;

  // lw and sw never share the mem stage
  a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mem.read && mem.write));
  a_word_aligned: assert property (@(posedge clk) disable iff (reset)
    (mem.read || mem.write) |-> mem.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/inst_memory.sv
`default_nettype none
`include "rv_settings.svh"

module inst_memory (
  input  wire              clk,
  input  wire              load_en,   // only while the core is in reset
  input  wire  [`XLEN-1:0] load_addr, // byte address
  input  wire  [`XLEN-1:0] load_data,
  input  wire  [`XLEN-1:0] addr,      // fetch pc
  output logic [`XLEN-1:0] inst
);

  localparam int IDX_W = $clog2(`IMEM_WORDS);

  logic [`XLEN-1:0] rom [`IMEM_WORDS];

  // words never loaded fetch as a nop
  initial begin
    for (int i = 0; i < `IMEM_WORDS; i++) rom[i] = `NOP_INST;
  end

  always @(posedge clk) begin
    if (load_en) rom[load_addr[IDX_W+1:2]] <= load_data;
  end

  assign inst = rom[addr[IDX_W+1:2]]; // combinational fetch

endmodule

`default_nettype wire

// File: src/register_file.sv
`default_nettype none
`include "rv_settings.svh"

module register_file (
  input  wire                    clk,
  input  wire                    reset,
  input  wire  [`REG_ADDR_W-1:0] rs1_idx,
  input  wire  [`REG_ADDR_W-1:0] rs2_idx,
  input  wire                    we,
  input  wire  [`REG_ADDR_W-1:0] rd,
  input  wire  [`XLEN-1:0]       wdata,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  localparam int NUM_REGS = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage

  // one read port, x0 reads zero, a write in the same cycle is seen at once
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] idx);
    if (idx == '0) return '0;
    if (we && rd == idx) return wdata; // wb to id bypass
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_idx);
    rs2_data = read_port(rs2_idx);
  end

  // writes to x0 are dropped before they leave id
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset) !(we && rd == '0));

endmodule

`default_nettype wire

// File: verification/cpu_tb.sv
`default_nettype none
`include "rv_settings.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BODY_LEN     = 60;
  localparam int PROG_LEN     = BODY_LEN + 2; // body plus addi x17 and ecall
  localparam int RESET_CYCLES = 5;
  localparam int HALT_HOLD    = 20;
  // load and reset cycles plus 20 per instruction plus 50
  localparam int TIMEOUT_CYCLES = PROG_LEN + RESET_CYCLES + 20 * PROG_LEN + 50;

  typedef enum {
    k_add, k_sub, k_and, k_or, k_slt, k_addi, k_lw, k_sw, k_beq, k_bne, k_jal, k_ecall
  } kind_e;

  logic                   clk;
  logic                   reset;
  logic                   load_en;
  logic [`XLEN-1:0]       load_addr;
  logic [`XLEN-1:0]       load_data;
  logic                   is_halted;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  // program kept as fields that build each word
  kind_e       p_kind [PROG_LEN];
  logic [4:0]  p_rd   [PROG_LEN];
  logic [4:0]  p_rs1  [PROG_LEN];
  logic [4:0]  p_rs2  [PROG_LEN];
  logic [31:0] p_imm  [PROG_LEN]; // byte offset for branches and jal
  logic [31:0] p_word [PROG_LEN];

  // expected trace from the isa model
  logic [4:0]  exp_rd   [$];
  logic [31:0] exp_data [$];
  int          exp_at   [$]; // instruction index that wrote

  integer seed;
  int     wb_count;
  int     cycles_out_of_reset;
  bit     halted_seen;

  tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

  cpu_top uut (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .is_halted (is_halted),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else report_failure($sformatf("mismatch %s expected 'h%0h actual 'h%0h",
                                    name, expected, actual));
  endtask

  // standard rv32i encodings
  function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [31:0] imm);
    case (k)
      k_add:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      k_sub:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      k_and:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
      k_or:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      k_slt:   return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
      k_addi:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      k_lw:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
      k_sw:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      k_beq:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
      k_bne:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
      k_jal:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
      default: return 32'h0000_0073; // ecall
    endcase
  endfunction

  task automatic build_program();
    int r;
    int step;
    for (int i = 0; i < BODY_LEN; i++) begin
      r          = $unsigned($random(seed)) % 16;
      p_rd[i]    = 5'(1 + $unsigned($random(seed)) % 7); // x1..x7 only
      p_rs1[i]   = 5'(1 + $unsigned($random(seed)) % 7);
      p_rs2[i]   = 5'(1 + $unsigned($random(seed)) % 7);
      p_imm[i]   = $random(seed) % 64; // small signed addi constant
      step       = 2 + $unsigned($random(seed)) % 5;
      case (r)
        0, 1:    p_kind[i] = k_add;
        2:       p_kind[i] = k_sub;
        3:       p_kind[i] = k_and;
        4:       p_kind[i] = k_or;
        5, 15:   p_kind[i] = k_slt;
        6, 7, 8: p_kind[i] = k_addi;
        9, 10:   p_kind[i] = k_lw;
        11:      p_kind[i] = k_sw;
        12:      p_kind[i] = k_beq;
        13:      p_kind[i] = k_bne;
        default: p_kind[i] = k_jal;
      endcase
      // too close to the end for a forward jump
      if ((p_kind[i] == k_beq || p_kind[i] == k_bne || p_kind[i] == k_jal) &&
          i + 2 >= BODY_LEN) p_kind[i] = k_addi;
      if (i + step >= BODY_LEN) step = BODY_LEN - 1 - i; // target stays in the body
      case (p_kind[i])
        k_lw, k_sw: begin
          p_rs1[i] = 5'd0;
          p_imm[i] = ($unsigned($random(seed)) % 8) * 4; // few words, so loads hit stores
        end
        k_beq, k_bne: begin
          if (($random(seed) & 1) != 0) p_rs2[i] = p_rs1[i]; // bias toward equal
          p_imm[i] = step * 4;
        end
        k_jal: p_imm[i] = step * 4;
        default: ;
      endcase
      if (p_kind[i] == k_sw || p_kind[i] == k_beq || p_kind[i] == k_bne) p_rd[i] = 5'd0;
      p_word[i] = encode(p_kind[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
    end
    // addi x17, x0, 10 then ecall
    p_kind[BODY_LEN] = k_addi;
    p_rd[BODY_LEN]   = 5'd17;
    p_rs1[BODY_LEN]  = 5'd0;
    p_rs2[BODY_LEN]  = 5'd0;
    p_imm[BODY_LEN]  = 32'd10;
    p_kind[BODY_LEN + 1] = k_ecall;
    p_rd[BODY_LEN + 1]   = 5'd0;
    p_rs1[BODY_LEN + 1]  = 5'd0;
    p_rs2[BODY_LEN + 1]  = 5'd0;
    p_imm[BODY_LEN + 1]  = 32'd0;
    for (int i = BODY_LEN; i < PROG_LEN; i++) begin
      p_word[i] = encode(p_kind[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
    end
  endtask

  // isa model steps one instruction at a time and records every write to x1..x31
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] ram  [64];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    int          pc_i;
    int          next;
    bit          done;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    for (int w = 0; w < 64; w++) ram[w] = '0; // dmem cleared by reset
    pc_i = 0;
    done = 1'b0;
    while (!done && pc_i < PROG_LEN) begin
      a    = regs[p_rs1[pc_i]];
      b    = regs[p_rs2[pc_i]];
      v    = '0;
      next = pc_i + 1;
      case (p_kind[pc_i])
        k_add:  v = a + b;
        k_sub:  v = a - b;
        k_and:  v = a & b;
        k_or:   v = a | b;
        k_slt:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        k_addi: v = a + p_imm[pc_i];
        k_lw:   v = ram[((a + p_imm[pc_i]) >> 2) % 64];
        k_sw:   ram[((a + p_imm[pc_i]) >> 2) % 64] = b;
        k_beq:  if (a == b) next = pc_i + $signed(p_imm[pc_i]) / 4;
        k_bne:  if (a != b) next = pc_i + $signed(p_imm[pc_i]) / 4;
        k_jal: begin
          v    = 32'((pc_i + 1) * 4); // link
          next = pc_i + $signed(p_imm[pc_i]) / 4;
        end
        default: done = (regs[17] == 32'd10); // ecall
      endcase
      if (p_rd[pc_i] != 5'd0) begin
        regs[p_rd[pc_i]] = v;
        exp_rd.push_back(p_rd[pc_i]);
        exp_data.push_back(v);
        exp_at.push_back(pc_i);
      end
      pc_i = next;
    end
  endtask

  // trace monitor samples registered outputs at the edge
  always @(posedge clk) begin
    if (!reset) begin
      cycles_out_of_reset++;
      if (cycles_out_of_reset == 1)
        assert (wb_valid === 1'b0 && is_halted === 1'b0)
          else report_failure("wb_valid or is_halted not low right after reset");
      if (wb_valid) begin
        assert (!is_halted && !halted_seen)
          else report_failure("writeback seen after the core halted");
        assert (wb_count < exp_rd.size())
          else report_failure("more writebacks than the model produced");
        assert (wb_count > 0 || cycles_out_of_reset >= 5)
          else report_failure($sformatf("first writeback only %0d cycles after reset",
                                        cycles_out_of_reset));
        check_value($sformatf("trace %0d rd (inst %0d)", wb_count, exp_at[wb_count]),
                    32'(exp_rd[wb_count]), 32'(wb_rd));
        check_value($sformatf("trace %0d data (inst %0d)", wb_count, exp_at[wb_count]),
                    exp_data[wb_count], wb_data);
        wb_count++;
      end
      if (halted_seen)
        assert (is_halted === 1'b1) else report_failure("is_halted fell without reset");
      if (is_halted === 1'b1 && !halted_seen) begin
        check_value("writeback count at halt", exp_rd.size(), wb_count);
        halted_seen = 1'b1;
      end
    end
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_failure($sformatf("timeout, the core did not finish within %0d cycles",
                             TIMEOUT_CYCLES));
  end

  initial begin
    reset               = 1'b1;
    load_en             = 1'b0;
    load_addr           = '0;
    load_data           = '0;
    wb_count            = 0;
    cycles_out_of_reset = 0;
    halted_seen         = 1'b0;
    seed                = 32'hfc75812d;
    build_program();
    run_model();
    @(posedge clk);
    for (int i = 0; i < PROG_LEN; i++) begin // program goes in while reset is high
      load_en   <= 1'b1;
      load_addr <= 32'(i * 4);
      load_data <= p_word[i];
      @(posedge clk);
    end
    load_en <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    wait (halted_seen);
    repeat (HALT_HOLD) @(posedge clk); // monitor keeps checking the quiet halt
    @(negedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #(PERIOD_NS / 2.0) clk = ~clk; // first rising edge at half a period

endmodule

`default_nettype wire
